/* logic/thumb_ctrl_settings.svh */
`ifndef THUMB_CTRL_SETTINGS_SVH
`define THUMB_CTRL_SETTINGS_SVH

// width of a data word on the datapath
`define THUMB_WORD_W 32

// every instruction handled by the decoder is a single halfword
`define THUMB_INSTR_W 16

// size of the architectural register file
`define THUMB_NUM_REGS 16

// the register list field covers r0 to r7
`define THUMB_LOW_REGS 8

// stack pointer register number
`define THUMB_SP_REG 13

// each transferred register moves one full word
`define THUMB_REG_BYTES 4

`endif

/* logic/thumb_ctrl_pkg.sv */
`include "thumb_ctrl_settings.svh"

package thumb_ctrl_pkg;

    typedef logic [`THUMB_WORD_W-1:0]           word_t;
    typedef logic [`THUMB_INSTR_W-1:0]          instr_t;
    typedef logic [$clog2(`THUMB_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [`THUMB_NUM_REGS-1:0]         reg_mask_t;
    // one extra bit so that a full list of 16 still fits
    typedef logic [$clog2(`THUMB_NUM_REGS):0]   beat_cnt_t;

    typedef enum logic [3:0] {
        GRP_SHIFT_IMM,
        GRP_DATA_PROC,
        GRP_LS_REG,
        GRP_LS_IMM,
        GRP_LS_SP,
        GRP_MISC,
        GRP_STM,
        GRP_LDM,
        GRP_OTHER
    } op_group_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_BIC,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR,
        ALU_ROR,
        ALU_ADC,
        ALU_SBC,
        ALU_MUL
    } alu_op_e;

    // SRC_ACC selects the offset that the control unit drives on imm_o
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_ZERO,
        SRC_ACC
    } alu_src_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_src_e;

    // an all-zero word is the idle bundle with every enable low
    typedef struct packed {
        logic     update_flag;
        logic     mem_write;
        logic     mem_read;
        logic     reg_write;
        wb_src_e  wb_src;
        alu_src_e alu_a_sel;
        alu_src_e alu_b_sel;
        alu_op_e  alu_op;
        logic     addr2_from_ctrl;
        logic     dest_from_ctrl;
        logic     sel_reg3;
    } ctrl_word_t;

    // index of the lowest set bit, zero when the mask is empty
    function automatic reg_addr_t lowest_set_reg(input reg_mask_t mask);
        reg_addr_t idx;
        idx = '0;
        for (int i = `THUMB_NUM_REGS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = reg_addr_t'(i);
            end
        end
        return idx;
    endfunction

    // only r0 to r7 are looked at, which is all a descending LDM can hold
    function automatic reg_addr_t highest_set_low_reg(input reg_mask_t mask);
        reg_addr_t idx;
        idx = '0;
        for (int i = 0; i < `THUMB_LOW_REGS; i++) begin
            if (mask[i]) begin
                idx = reg_addr_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic beat_cnt_t reg_count(input reg_mask_t mask);
        beat_cnt_t cnt;
        cnt = '0;
        for (int i = 0; i < `THUMB_NUM_REGS; i++) begin
            cnt = cnt + beat_cnt_t'(mask[i]);
        end
        return cnt;
    endfunction

endpackage

/* logic/alu_op_decoder.sv */
module alu_op_decoder (
    input  thumb_ctrl_pkg::instr_t     instr_i,
    output thumb_ctrl_pkg::ctrl_word_t single_ctrl_o
);
    import thumb_ctrl_pkg::*;

    op_group_e   group;
    logic [4:0]  shift_code;
    logic [3:0]  dp_code;

    // top-level class from the leading opcode bits
    always_comb begin
        casez (instr_i[15:10])
            6'b00_????: group = GRP_SHIFT_IMM;
            6'b01_0000: group = GRP_DATA_PROC;
            6'b01_01??: group = GRP_LS_REG;
            6'b01_1???: group = GRP_LS_IMM;
            6'b10_00??: group = GRP_LS_IMM;
            6'b10_01??: group = GRP_LS_SP;
            6'b10_11??: group = GRP_MISC;
            6'b11_000?: group = GRP_STM;
            6'b11_001?: group = GRP_LDM;
            default:    group = GRP_OTHER;
        endcase
    end

    always_comb begin
        shift_code    = instr_i[13:9];
        dp_code       = instr_i[9:6];
        single_ctrl_o = '0;

        case (group)
            GRP_SHIFT_IMM: begin
                // nearly every op here sets flags and writes a result
                single_ctrl_o.update_flag = 1'b1;
                single_ctrl_o.reg_write   = 1'b1;
                casez (shift_code)
                    5'b000??: begin
                        single_ctrl_o.alu_op    = ALU_LSL;
                        single_ctrl_o.alu_b_sel = SRC_IMM;
                    end
                    5'b001??: begin
                        single_ctrl_o.alu_op    = ALU_LSR;
                        single_ctrl_o.alu_b_sel = SRC_IMM;
                    end
                    5'b010??: begin
                        single_ctrl_o.alu_op    = ALU_ASR;
                        single_ctrl_o.alu_b_sel = SRC_IMM;
                    end
                    5'b01100: single_ctrl_o.alu_op = ALU_ADD;
                    5'b01101: single_ctrl_o.alu_op = ALU_SUB;
                    5'b01110, 5'b110??: begin
                        single_ctrl_o.alu_op    = ALU_ADD;
                        single_ctrl_o.alu_b_sel = SRC_IMM;
                    end
                    5'b01111, 5'b111??: begin
                        single_ctrl_o.alu_op    = ALU_SUB;
                        single_ctrl_o.alu_b_sel = SRC_IMM;
                    end
                    5'b100??: begin
                        // mov is 0 + imm8
                        single_ctrl_o.alu_op    = ALU_ADD;
                        single_ctrl_o.alu_a_sel = SRC_ZERO;
                        single_ctrl_o.alu_b_sel = SRC_IMM;
                    end
                    5'b101??: begin
                        single_ctrl_o.alu_op    = ALU_SUB;
                        single_ctrl_o.alu_b_sel = SRC_IMM;
                        single_ctrl_o.reg_write = 1'b0;
                    end
                    default: ;
                endcase
            end

            GRP_DATA_PROC: begin
                single_ctrl_o.update_flag = 1'b1;
                single_ctrl_o.reg_write   = 1'b1;
                case (dp_code)
                    4'h0: single_ctrl_o.alu_op = ALU_AND;
                    4'h1: single_ctrl_o.alu_op = ALU_XOR;
                    4'h2: single_ctrl_o.alu_op = ALU_LSL;
                    4'h3: single_ctrl_o.alu_op = ALU_LSR;
                    4'h4: single_ctrl_o.alu_op = ALU_ASR;
                    4'h5: single_ctrl_o.alu_op = ALU_ADC;
                    4'h6: single_ctrl_o.alu_op = ALU_SBC;
                    4'h7: single_ctrl_o.alu_op = ALU_ROR;
                    4'h8: begin
                        // tst, flags only
                        single_ctrl_o.alu_op    = ALU_AND;
                        single_ctrl_o.reg_write = 1'b0;
                    end
                    4'h9: begin
                        // negate as 0 - rm
                        single_ctrl_o.alu_op    = ALU_SUB;
                        single_ctrl_o.alu_a_sel = SRC_ZERO;
                    end
                    4'hA: begin
                        single_ctrl_o.alu_op    = ALU_SUB;
                        single_ctrl_o.reg_write = 1'b0;
                    end
                    4'hB: begin
                        single_ctrl_o.alu_op    = ALU_ADD;
                        single_ctrl_o.reg_write = 1'b0;
                    end
                    4'hC: single_ctrl_o.alu_op = ALU_OR;
                    4'hD: single_ctrl_o.alu_op = ALU_MUL;
                    4'hE: single_ctrl_o.alu_op = ALU_BIC;
                    default: single_ctrl_o.alu_op = ALU_NOT;
                endcase
            end

            GRP_LS_REG: begin
                single_ctrl_o.wb_src = WB_MEM;
                // bit 11 marks the loads, plus ldrsb in the store half
                if (instr_i[11] || (instr_i[10:9] == 2'b11)) begin
                    single_ctrl_o.mem_read  = 1'b1;
                    single_ctrl_o.reg_write = 1'b1;
                end else begin
                    single_ctrl_o.mem_write = 1'b1;
                    single_ctrl_o.sel_reg3  = 1'b1;
                end
            end

            GRP_LS_IMM, GRP_LS_SP: begin
                single_ctrl_o.wb_src    = WB_MEM;
                single_ctrl_o.alu_b_sel = SRC_IMM;
                if (instr_i[11]) begin
                    single_ctrl_o.mem_read  = 1'b1;
                    single_ctrl_o.reg_write = 1'b1;
                end else begin
                    single_ctrl_o.mem_write = 1'b1;
                    single_ctrl_o.sel_reg3  = 1'b1;
                end
            end

            // block transfers are built downstream, the rest decode to no-ops
            default: ;
        endcase
    end

endmodule

/* logic/reg_list_sequencer.sv */
`include "thumb_ctrl_settings.svh"

module reg_list_sequencer (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      valid_i,
    input  logic                      stall_i,
    input  logic                      descending_i,
    input  thumb_ctrl_pkg::reg_mask_t list_i,
    input  thumb_ctrl_pkg::reg_addr_t base_reg_i,
    output thumb_ctrl_pkg::reg_mask_t remaining_o,
    output thumb_ctrl_pkg::beat_cnt_t beat_o,
    output logic                      base_in_list_o
);
    import thumb_ctrl_pkg::*;

    reg_mask_t pending;
    reg_addr_t sel_reg;
    logic      clear_state;

    always_comb begin
        pending = list_i & remaining_o;
        // LDM walks from r7 downward, everything else from r0 upward
        if (descending_i) begin
            sel_reg = highest_set_low_reg(pending);
        end else begin
            sel_reg = lowest_set_reg(pending);
        end
        // a finished or dropped transfer rearms the sequencer for the next one
        clear_state = reset_i || !stall_i || !valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (clear_state) begin
            remaining_o    <= '1;
            beat_o         <= '0;
            base_in_list_o <= 1'b0;
        end else begin
            remaining_o <= remaining_o & ~(reg_mask_t'(1) << sel_reg);
            beat_o      <= beat_o + beat_cnt_t'(1);
            // sticky, the final beat needs it after the base was loaded
            if (sel_reg == base_reg_i) begin
                base_in_list_o <= 1'b1;
            end
        end
    end

    beat_bound: assert property (@(posedge clk_i) disable iff (reset_i)
        beat_o <= beat_cnt_t'(`THUMB_NUM_REGS));

    // each held cycle retires exactly one register of the list from the mask
    mask_drop_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        $past(stall_i && valid_i && !reset_i)
            |-> $onehot($past(remaining_o & list_i) & ~remaining_o));

endmodule

/* logic/block_transfer_ctrl.sv */
`include "thumb_ctrl_settings.svh"

module block_transfer_ctrl (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       valid_i,
    input  thumb_ctrl_pkg::instr_t     instr_i,
    input  thumb_ctrl_pkg::ctrl_word_t single_ctrl_i,
    input  thumb_ctrl_pkg::reg_mask_t  remaining_i,
    input  thumb_ctrl_pkg::beat_cnt_t  beat_i,
    input  logic                       base_in_list_i,
    output logic                       stall_o,
    output logic                       descending_o,
    output thumb_ctrl_pkg::reg_mask_t  list_o,
    output thumb_ctrl_pkg::ctrl_word_t ctrl_o,
    output thumb_ctrl_pkg::word_t      imm_o,
    output thumb_ctrl_pkg::reg_addr_t  reg_addr_o,
    output logic                       stall_out_o
);
    import thumb_ctrl_pkg::*;

    logic       is_push;
    logic       is_pop;
    logic       is_stm;
    logic       is_ldm;
    logic       is_block;
    reg_mask_t  pending;
    reg_addr_t  cur_reg;
    reg_addr_t  base_reg;
    word_t      total_bytes;
    word_t      beat_bytes;
    ctrl_word_t blk_ctrl;
    word_t      blk_imm;
    reg_addr_t  blk_reg;

    always_comb begin
        is_push = 1'b0;
        is_pop  = 1'b0;
        is_stm  = 1'b0;
        is_ldm  = 1'b0;
        casez (instr_i[15:9])
            7'b1011_010: is_push = 1'b1;
            7'b1011_110: is_pop  = 1'b1;
            7'b1100_0??: is_stm  = 1'b1;
            7'b1100_1??: is_ldm  = 1'b1;
            default: ;
        endcase
        is_block     = is_push || is_pop || is_stm || is_ldm;
        descending_o = is_ldm;

        // bit 8 of PUSH adds LR, the same bit on POP would be the PC and is ignored
        list_o = '0;
        if (is_push) begin
            list_o[7:0] = instr_i[7:0];
            list_o[14]  = instr_i[8];
        end else if (is_block) begin
            list_o[7:0] = instr_i[7:0];
        end

        if (is_push || is_pop) begin
            base_reg = reg_addr_t'(`THUMB_SP_REG);
        end else begin
            base_reg = reg_addr_t'(instr_i[10:8]);
        end

        pending = list_o & remaining_i;
        if (is_ldm) begin
            cur_reg = highest_set_low_reg(pending);
        end else begin
            cur_reg = lowest_set_reg(pending);
        end
        stall_o = is_block && (pending != '0);

        total_bytes = word_t'(reg_count(list_o)) * `THUMB_REG_BYTES;
        beat_bytes  = word_t'(beat_i) * `THUMB_REG_BYTES;
    end

    always_comb begin
        blk_ctrl           = '0;
        blk_ctrl.alu_b_sel = SRC_ACC;
        blk_ctrl.alu_op    = is_push ? ALU_SUB : ALU_ADD;
        if (stall_o) begin
            blk_reg = cur_reg;
            if (is_push || is_stm) begin
                blk_ctrl.mem_write       = 1'b1;
                blk_ctrl.addr2_from_ctrl = 1'b1;
            end else begin
                blk_ctrl.mem_read       = 1'b1;
                blk_ctrl.reg_write      = 1'b1;
                blk_ctrl.wb_src         = WB_MEM;
                blk_ctrl.dest_from_ctrl = 1'b1;
            end
            // PUSH counts down from the new stack top, LDM from the top word of the block
            if (is_push) begin
                blk_imm = total_bytes - beat_bytes;
            end else if (is_ldm) begin
                blk_imm = total_bytes - beat_bytes - `THUMB_REG_BYTES;
            end else begin
                blk_imm = beat_bytes;
            end
        end else begin
            // last beat moves the base or SP past the whole block
            blk_reg                 = base_reg;
            blk_imm                 = total_bytes;
            blk_ctrl.dest_from_ctrl = 1'b1;
            blk_ctrl.reg_write      = !(is_ldm && base_in_list_i);
        end
    end

    always_comb begin
        stall_out_o = valid_i && stall_o;
        if (!valid_i) begin
            ctrl_o     = '0;
            imm_o      = '0;
            reg_addr_o = '0;
        end else if (is_block) begin
            ctrl_o     = blk_ctrl;
            imm_o      = blk_imm;
            reg_addr_o = blk_reg;
        end else begin
            ctrl_o     = single_ctrl_i;
            imm_o      = '0;
            reg_addr_o = '0;
        end
    end

    // while the stall is up the upstream stage holds the same valid instruction
    stall_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        stall_out_o |=> valid_i && $stable(instr_i));

endmodule

/* logic/thumb_ctrl_top.sv */
module thumb_ctrl_top (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       valid_i,
    input  thumb_ctrl_pkg::instr_t     instr_i,
    output thumb_ctrl_pkg::ctrl_word_t ctrl_o,
    output thumb_ctrl_pkg::word_t      imm_o,
    output thumb_ctrl_pkg::reg_addr_t  reg_addr_o,
    output logic                       stall_o
);
    import thumb_ctrl_pkg::*;

    ctrl_word_t single_ctrl;
    reg_mask_t  remaining;
    reg_mask_t  list;
    beat_cnt_t  beat;
    logic       base_in_list;
    logic       stall;
    logic       descending;

    alu_op_decoder u_alu_op_decoder (
        .instr_i       (instr_i),
        .single_ctrl_o (single_ctrl)
    );

    // base field of STM/LDM, used to spot a base register inside the list
    reg_list_sequencer u_reg_list_sequencer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .stall_i        (stall),
        .descending_i   (descending),
        .list_i         (list),
        .base_reg_i     ({1'b0, instr_i[10:8]}),
        .remaining_o    (remaining),
        .beat_o         (beat),
        .base_in_list_o (base_in_list)
    );

    block_transfer_ctrl u_block_transfer_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .instr_i        (instr_i),
        .single_ctrl_i  (single_ctrl),
        .remaining_i    (remaining),
        .beat_i         (beat),
        .base_in_list_i (base_in_list),
        .stall_o        (stall),
        .descending_o   (descending),
        .list_o         (list),
        .ctrl_o         (ctrl_o),
        .imm_o          (imm_o),
        .reg_addr_o     (reg_addr_o),
        .stall_out_o    (stall_o)
    );

endmodule

/* tb/thumb_ctrl_tb.sv */
module thumb_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import thumb_ctrl_pkg::*;

    // each trace row holds valid, instr, ctrl, imm, reg and stall
    localparam int TRACE_ROWS   = 57;
    localparam int TRACE_COLS   = 6;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES   = 2 * TRACE_ROWS + RESET_CYCLES;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       valid_i;
    instr_t     instr_i;
    ctrl_word_t ctrl_o;
    word_t      imm_o;
    reg_addr_t  reg_addr_o;
    logic       stall_o;

    logic [31:0] trace_mem [0:TRACE_ROWS*TRACE_COLS-1];
    int          cycle_cnt = 0;

    thumb_ctrl_top DUT (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .ctrl_o     (ctrl_o),
        .imm_o      (imm_o),
        .reg_addr_o (reg_addr_o),
        .stall_o    (stall_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_t got,
                              input ctrl_word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s at cycle %0d: got 0x%04h expected 0x%04h",
                     name, cycle_cnt, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s at cycle %0d: got 0x%08h expected 0x%08h",
                     name, cycle_cnt, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got,
                             input reg_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s at cycle %0d: got 0x%0h expected 0x%0h",
                     name, cycle_cnt, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s at cycle %0d: got 0x%0h expected 0x%0h",
                     name, cycle_cnt, got, exp);
            abort_run();
        end
    endtask

    // with valid low every output must sit at its idle value
    task automatic check_idle();
        check_ctrl("ctrl_o", ctrl_o, '0);
        check_word("imm_o", imm_o, '0);
        check_reg("reg_addr_o", reg_addr_o, '0);
        check_bit("stall_o", stall_o, 1'b0);
    endtask

    task automatic compare_row(input int row);
        int base;
        base = row * TRACE_COLS;
        check_ctrl("ctrl_o", ctrl_o, ctrl_word_t'(trace_mem[base+2][15:0]));
        check_word("imm_o", imm_o, word_t'(trace_mem[base+3]));
        check_reg("reg_addr_o", reg_addr_o, reg_addr_t'(trace_mem[base+4][3:0]));
        check_bit("stall_o", stall_o, trace_mem[base+5][0]);
    endtask

    initial begin
        reset_i <= 1'b1;
        valid_i <= 1'b0;
        instr_i <= '0;

        $readmemh("tb/ctrl_trace.txt", trace_mem);
        if ($isunknown(trace_mem[0]) || $isunknown(trace_mem[TRACE_ROWS*TRACE_COLS-1])) begin
            $display("trace file tb/ctrl_trace.txt is missing or shorter than expected");
            abort_run();
        end

        // outputs are checked on the falling edge, once the decode has settled
        repeat (RESET_CYCLES) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_idle();
        end

        for (int row = 0; row < TRACE_ROWS; row++) begin
            @(posedge clk_i);
            reset_i <= 1'b0;
            valid_i <= trace_mem[row*TRACE_COLS][0];
            instr_i <= instr_t'(trace_mem[row*TRACE_COLS+1][15:0]);
            @(negedge clk_i);
            compare_row(row);
        end

        $display("STATUS: PASS");
        $finish;
    end

    // a stuck run ends here instead of hanging
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: trace did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

endmodule

/* tb/ctrl_trace.txt */
// columns: valid instr ctrl imm reg stall, all hex, one row per clock cycle
// ctrl is the packed control word, imm the 32-bit offset, reg the register number
0 0000 0000 00000000 0 0
0 B505 0000 00000000 0 0
// shift by immediate, add/sub register and immediate, mov, cmp
1 00D1 90B8 00000000 0 0
1 08D1 90C0 00000000 0 0
1 10D1 90C8 00000000 0 0
1 188B 9000 00000000 0 0
1 1A8B 9008 00000000 0 0
1 1C8B 9080 00000000 0 0
1 1E8B 9088 00000000 0 0
1 2255 9480 00000000 0 0
1 2A55 8088 00000000 0 0
// the 16 data-processing ops in code order
1 400A 9010 00000000 0 0
1 404A 9020 00000000 0 0
1 408A 9038 00000000 0 0
1 40CA 9040 00000000 0 0
1 410A 9048 00000000 0 0
1 414A 9058 00000000 0 0
1 418A 9060 00000000 0 0
1 41CA 9050 00000000 0 0
1 420A 8010 00000000 0 0
1 424A 9408 00000000 0 0
1 428A 8008 00000000 0 0
1 42CA 8000 00000000 0 0
1 430A 9018 00000000 0 0
1 434A 9068 00000000 0 0
1 438A 9030 00000000 0 0
1 43CA 9028 00000000 0 0
// single load/store, register offset, immediate offset, SP-relative
1 5088 4801 00000000 0 0
1 5888 3800 00000000 0 0
1 6088 4881 00000000 0 0
1 6888 3880 00000000 0 0
1 9204 4881 00000000 0 0
1 9A04 3880 00000000 0 0
// push {r0, r2, lr} then an add in the very next cycle
1 B505 418C 0000000C 0 1
1 B505 418C 00000008 2 1
1 B505 418C 00000004 E 1
1 B505 118A 0000000C D 0
1 188B 9000 00000000 0 0
// stm r1!, {r0, r3, r5} followed by an idle cycle
1 C129 4184 00000000 0 1
1 C129 4184 00000004 3 1
1 C129 4184 00000008 5 1
1 C129 1182 0000000C 1 0
0 C129 0000 00000000 0 0
// pop {r1, r4}
1 BC12 3982 00000000 1 1
1 BC12 3982 00000004 4 1
1 BC12 1182 00000008 D 0
// ldm r2!, {r0, r1, r6}
1 CA43 3982 00000008 6 1
1 CA43 3982 00000004 1 1
1 CA43 3982 00000000 0 1
1 CA43 1182 0000000C 2 0
// ldm r3!, {r1, r3, r5} keeps the loaded base
1 CB2A 3982 00000008 5 1
1 CB2A 3982 00000004 3 1
1 CB2A 3982 00000000 1 1
1 CB2A 0182 0000000C 3 0
// stm r4!, {} gives only the final beat
1 C400 1182 00000000 4 0
1 2255 9480 00000000 0 0
0 0000 0000 00000000 0 0

/* sources.f */
+incdir+logic
logic/thumb_ctrl_pkg.sv
logic/alu_op_decoder.sv
logic/reg_list_sequencer.sv
logic/block_transfer_ctrl.sv
logic/thumb_ctrl_top.sv
tb/thumb_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module thumb_ctrl_tb \
    -o thumb_ctrl_sim

# the simulator exits non-zero on a failing check, the log decides the result
./obj_dir/thumb_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
